//--- compile.f
+incdir+tb
source/bpu_pkg.sv
source/table_if.sv
source/pred_table.sv
source/fetch_predictor.sv
source/branch_update.sv
source/bpu_top.sv
tb/bpu_tb.sv

//--- tb/bpu_ref_model.svh
`ifndef BPU_REF_MODEL_SVH
`define BPU_REF_MODEL_SVH

// reference copies of the four tables and the global history
bpu_pkg::counter_t      bm_m  [512];
bpu_pkg::tagged_entry_t t0_m  [256];
bpu_pkg::tagged_entry_t t1_m  [256];
bpu_pkg::btb_entry_t    btb_m [256];
bpu_pkg::hist_t         hist_m;

task automatic reset_model();
    for (int i = 0; i < 512; i++) begin
        bm_m[i] = 2'b01;
    end
    for (int i = 0; i < 256; i++) begin
        t0_m[i]  = '{valid: 1'b0, tag: 10'h0, ctr: 2'b01};
        t1_m[i]  = '{valid: 1'b0, tag: 10'h0, ctr: 2'b01};
        btb_m[i] = '{valid: 1'b0, tag: 22'h0, target: 32'h0};
    end
    hist_m = 16'h0;
endtask

function automatic logic [1:0] sat_step(input logic [1:0] c, input logic tk);
    if (tk) begin
        return (c == 2'b11) ? c : c + 2'd1;
    end
    return (c == 2'b00) ? c : c - 2'd1;
endfunction

// indices and full tags of both tagged tables
task automatic tagged_keys(input bpu_pkg::addr_t pc, input bpu_pkg::hist_t h,
                           output logic [7:0] i0, output logic [7:0] i1,
                           output logic [9:0] g0, output logic [9:0] g1);
    i0 = pc[7:0] ^ h[7:0];
    i1 = pc[7:0] ^ h[15:8];
    g0 = pc[17:8] ^ h[15:6];
    g1 = pc[17:8] ^ {2'b00, h[7:0]};
endtask

// provider 2 is T1, 1 is T0, 0 is bimodal
task automatic find_provider(input bpu_pkg::addr_t pc, input bpu_pkg::hist_t h,
                             output int prov, output logic dir);
    logic [7:0] i0;
    logic [7:0] i1;
    logic [9:0] g0;
    logic [9:0] g1;
    tagged_keys(pc, h, i0, i1, g0, g1);
    if (t1_m[i1].valid && (t1_m[i1].tag[9:4] == g1[9:4])) begin
        prov = 2;
        dir  = t1_m[i1].ctr[1];
    end else if (t0_m[i0].valid && (t0_m[i0].tag[9:4] == g0[9:4])) begin
        prov = 1;
        dir  = t0_m[i0].ctr[1];
    end else begin
        prov = 0;
        dir  = bm_m[pc[9:1]][1];
    end
endtask

task automatic predict_model(input bpu_pkg::addr_t pc, input bpu_pkg::addr_t inst,
                             output logic br, output logic tk,
                             output bpu_pkg::addr_t npc);
    int                  prov;
    logic                dir;
    logic [6:0]          op;
    bpu_pkg::btb_entry_t b;
    op = inst[6:0];
    br = (op == 7'b1100011) || (op == 7'b1101111) || (op == 7'b1100111);
    find_provider(pc, hist_m, prov, dir);
    tk = (op == 7'b1101111) || ((op == 7'b1100011) && dir);
    b  = btb_m[pc[9:2]];
    if (!tk) begin
        npc = pc + 32'd4;
    end else if (b.valid && (b.tag == pc[31:10])) begin
        npc = b.target;
    end else if (op == 7'b1101111) begin
        npc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    end else begin
        npc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    end
endtask

task automatic update_model(input logic tk, input bpu_pkg::addr_t pc,
                            input bpu_pkg::hist_t h, input bpu_pkg::addr_t tgt);
    int         prov;
    logic       dir;
    logic [7:0] i0;
    logic [7:0] i1;
    logic [9:0] g0;
    logic [9:0] g1;
    tagged_keys(pc, h, i0, i1, g0, g1);
    find_provider(pc, h, prov, dir);
    if (prov == 2) begin
        t1_m[i1].ctr = (dir == tk) ? sat_step(t1_m[i1].ctr, tk) : {tk, tk};
    end else if (prov == 1) begin
        t0_m[i0].ctr = (dir == tk) ? sat_step(t0_m[i0].ctr, tk) : {tk, tk};
    end else if (dir != tk) begin
        // weak entry in the actual direction
        if (t1_m[i1].tag != g1) begin
            t1_m[i1] = '{valid: 1'b1, tag: g1, ctr: {tk, ~tk}};
        end else if (t0_m[i0].tag != g0) begin
            t0_m[i0] = '{valid: 1'b1, tag: g0, ctr: {tk, ~tk}};
        end
    end
    bm_m[pc[9:1]] = sat_step(bm_m[pc[9:1]], tk);
    if (tk) begin
        btb_m[pc[9:2]] = '{valid: 1'b1, tag: pc[31:10], target: tgt};
    end
    hist_m = {hist_m[14:0], tk};
endtask

`endif

//--- tb/bpu_tb.sv
`default_nettype none

module bpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          reset_cycles = 5;
    localparam logic [31:0] nop      = 32'h0000_0013;
    localparam logic [31:0] beq8     = 32'h0020_8463;
    localparam logic [31:0] bne_back = 32'hfe20_9ee3;
    localparam logic [31:0] jal16    = 32'h0100_006f;
    localparam logic [31:0] jalr_ret = 32'h0000_8067;

    typedef struct packed {
        bpu_pkg::addr_t pc;
        bpu_pkg::addr_t inst;
        logic           rep;
        logic           taken;
        logic           use_ghist;
        bpu_pkg::addr_t epc;
        bpu_pkg::hist_t ehist;
        bpu_pkg::addr_t etarget;
        logic           exp_branch;
        logic           exp_taken;
        bpu_pkg::addr_t exp_pc;
        bpu_pkg::hist_t exp_hist;
    } row_t;

    logic           clk = 1'b0;
    logic           rst;
    bpu_pkg::addr_t if_pc;
    bpu_pkg::addr_t if_inst;
    logic           ex_valid;
    logic           ex_taken;
    bpu_pkg::addr_t ex_pc;
    bpu_pkg::hist_t ex_history;
    bpu_pkg::addr_t ex_target;
    logic           branch;
    logic           pred_taken;
    bpu_pkg::addr_t pred_pc;
    bpu_pkg::hist_t history;
    row_t           rows[$];
    logic [31:0]    lfsr;
    int             cycles = 0;
    int             max_cycles;

    `include "bpu_ref_model.svh"

    bpu_top uut (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc),
        .if_inst_i         (if_inst),
        .ex_branch_valid_i (ex_valid),
        .ex_branch_taken_i (ex_taken),
        .ex_pc_i           (ex_pc),
        .ex_history_i      (ex_history),
        .ex_target_i       (ex_target),
        .branch_o          (branch),
        .pred_taken_o      (pred_taken),
        .pred_pc_o         (pred_pc),
        .history_o         (history)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout: %0d cycles passed without finishing the rows", cycles);
            $display("test failed");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("test failed");
            $fatal(1, "first error reached");
        end
    endtask

    task automatic add_row(input logic [31:0] pc, input logic [31:0] inst, input logic rep,
                           input logic tk, input logic use_g, input logic [31:0] epc,
                           input logic [15:0] eh, input logic [31:0] tgt);
        row_t r;
        r           = '0;
        r.pc        = pc;
        r.inst      = inst;
        r.rep       = rep;
        r.taken     = tk;
        r.use_ghist = use_g;
        r.epc       = epc;
        r.ehist     = eh;
        r.etarget   = tgt;
        rows.push_back(r);
    endtask

    task automatic build_rows();
        logic [31:0] pc;
        logic [31:0] epc;
        logic [31:0] inst;
        logic [1:0]  sel;
        logic        rep;
        logic        tk;
        logic        use_g;
        logic [15:0] eh;
        logic [31:0] tgt;
        // idle state after reset
        add_row(32'h0000_1000, nop, 0, 0, 0, 0, 0, 0);
        add_row(32'h0000_1004, beq8, 0, 0, 0, 0, 0, 0);
        add_row(32'h0000_1008, jalr_ret, 0, 0, 0, 0, 0, 0);
        add_row(32'h0000_100c, bne_back, 0, 0, 0, 0, 0, 0);
        // jal immediate, then btb target
        add_row(32'h0000_2000, jal16, 1, 1, 0, 32'h0000_2000, 16'h0, 32'h0000_3000);
        add_row(32'h0000_2000, jal16, 0, 0, 0, 0, 0, 0);
        // bimodal up to taken and back down
        add_row(32'h0000_4008, beq8, 1, 1, 0, 32'h0000_4008, 16'h00a5, 32'h0000_4010);
        add_row(32'h0000_4008, beq8, 1, 1, 0, 32'h0000_4008, 16'h00a5, 32'h0000_4010);
        add_row(32'h0000_4008, beq8, 0, 0, 0, 0, 0, 0);
        for (int k = 0; k < 3; k++) begin
            add_row(32'h0000_4008, beq8, 1, 0, 0, 32'h0000_4008, 16'h00a5, 0);
        end
        add_row(32'h0000_4008, beq8, 0, 0, 0, 0, 0, 0);
        // random outcomes shift through the history
        for (int k = 0; k < 16; k++) begin
            tk = rand_bits(1);
            add_row(32'h0000_6000 + 4 * k, nop, 1, tk, 1, 32'h0000_6000 + 4 * k, 0,
                    32'h0000_6800);
        end
        // all-ones history keeps the tagged index steady
        for (int k = 0; k < 16; k++) begin
            add_row(32'h0000_7000, nop, 1, 1, 1, 32'h0000_7000, 0, 32'h0000_7400);
        end
        add_row(32'h0001_2340, beq8, 1, 1, 1, 32'h0001_2340, 0, 32'h0001_2348);
        add_row(32'h0001_2340, beq8, 1, 0, 1, 32'h0001_2340, 0, 0);
        add_row(32'h0001_2340, beq8, 1, 1, 1, 32'h0001_2340, 0, 32'h0001_2348);
        add_row(32'h0001_2340, beq8, 1, 1, 1, 32'h0001_2340, 0, 32'h0001_2348);
        add_row(32'h0001_2340, beq8, 1, 0, 1, 32'h0001_2340, 0, 0);
        add_row(32'h0001_2340, beq8, 0, 0, 0, 0, 0, 0);
        // zero t1 tag on a free slot sends the second allocation to T0
        // the last fetch runs under that history and sees T0 overrule the bimodal counter
        add_row(32'h0000_b680, beq8, 1, 1, 0, 32'h0000_b680, 16'h0055, 32'h0000_b688);
        add_row(32'h0000_b680, beq8, 1, 1, 0, 32'h0000_b680, 16'h0055, 32'h0000_b688);
        add_row(32'h0000_b680, beq8, 1, 0, 0, 32'h0000_b680, 16'hffb6, 0);
        add_row(32'h0000_b680, beq8, 0, 0, 0, 0, 0, 0);
        for (int k = 0; k < 64; k++) begin
            sel   = rand_bits(2);
            pc    = 32'h0001_0000 | (rand_bits(6) << 2);
            epc   = 32'h0001_0000 | (rand_bits(6) << 2);
            rep   = rand_bits(1);
            tk    = rand_bits(1);
            use_g = rand_bits(1);
            eh    = rand_bits(16);
            tgt   = rand_bits(32) & 32'hffff_fffc;
            inst  = (sel == 0) ? nop : (sel == 1) ? beq8 : (sel == 2) ? jal16 : bne_back;
            add_row(pc, inst, rep, tk, use_g, epc, eh, tgt);
        end
    endtask

    // entered on a falling edge, leaves on the next one
    task automatic apply_row(input int i);
        row_t           r;
        logic           eb;
        logic           et;
        bpu_pkg::addr_t ep;
        r = rows[i];
        if (r.use_ghist) begin
            r.ehist = hist_m;
        end
        predict_model(r.pc, r.inst, eb, et, ep);
        r.exp_branch = eb;
        r.exp_taken  = et;
        r.exp_pc     = ep;
        r.exp_hist   = hist_m;
        rows[i]      = r;
        if_pc      = r.pc;
        if_inst    = r.inst;
        ex_valid   = r.rep;
        ex_taken   = r.taken;
        ex_pc      = r.epc;
        ex_history = r.ehist;
        ex_target  = r.etarget;
        #2;
        check_value("branch_o", branch, r.exp_branch);
        check_value("pred_taken_o", pred_taken, r.exp_taken);
        check_value("pred_pc_o", pred_pc, r.exp_pc);
        check_value("history_o", history, r.exp_hist);
        @(posedge clk);
        if (r.rep) begin
            update_model(r.taken, r.epc, r.ehist, r.etarget);
        end
        @(negedge clk);
    endtask

    initial begin
        rst        = 1'b1;
        if_pc      = '0;
        if_inst    = '0;
        ex_valid   = 1'b0;
        ex_taken   = 1'b0;
        ex_pc      = '0;
        ex_history = '0;
        ex_target  = '0;
        lfsr       = 32'h0b92_0874;
        reset_model();
        build_rows();
        max_cycles = rows.size() + reset_cycles + 20;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/bpu_top.sv
`default_nettype none

module bpu_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire bpu_pkg::addr_t if_pc_i,
    input  wire bpu_pkg::addr_t if_inst_i,
    input  wire                 ex_branch_valid_i,
    input  wire                 ex_branch_taken_i,
    input  wire bpu_pkg::addr_t ex_pc_i,
    input  wire bpu_pkg::hist_t ex_history_i,
    input  wire bpu_pkg::addr_t ex_target_i,
    output logic                branch_o,
    output logic                pred_taken_o,
    output bpu_pkg::addr_t      pred_pc_o,
    output bpu_pkg::hist_t      history_o
);

    bpu_pkg::hist_t ghist;

    table_if #(.entry_t(bpu_pkg::counter_t), .idx_w(bpu_pkg::bm_idx_w)) bm_if ();
    table_if #(.entry_t(bpu_pkg::tagged_entry_t), .idx_w(bpu_pkg::tg_idx_w)) t0_if ();
    table_if #(.entry_t(bpu_pkg::tagged_entry_t), .idx_w(bpu_pkg::tg_idx_w)) t1_if ();
    table_if #(.entry_t(bpu_pkg::btb_entry_t), .idx_w(bpu_pkg::btb_idx_w)) btb_if ();

    pred_table #(
        .entry_t    (bpu_pkg::counter_t),
        .idx_w      (bpu_pkg::bm_idx_w),
        .init_entry (bpu_pkg::ctr_weak_nt)
    ) u_bm_table (.clk(clk), .rst(rst), .tbl(bm_if.store));

    pred_table #(
        .entry_t    (bpu_pkg::tagged_entry_t),
        .idx_w      (bpu_pkg::tg_idx_w),
        .init_entry (bpu_pkg::tagged_init)
    ) u_t0_table (.clk(clk), .rst(rst), .tbl(t0_if.store));

    pred_table #(
        .entry_t    (bpu_pkg::tagged_entry_t),
        .idx_w      (bpu_pkg::tg_idx_w),
        .init_entry (bpu_pkg::tagged_init)
    ) u_t1_table (.clk(clk), .rst(rst), .tbl(t1_if.store));

    pred_table #(
        .entry_t    (bpu_pkg::btb_entry_t),
        .idx_w      (bpu_pkg::btb_idx_w),
        .init_entry (bpu_pkg::btb_init)
    ) u_btb_table (.clk(clk), .rst(rst), .tbl(btb_if.store));

    fetch_predictor u_fetch (
        .if_pc_i      (if_pc_i),
        .if_inst_i    (if_inst_i),
        .ghist_i      (ghist),
        .bm           (bm_if.fetch),
        .t0           (t0_if.fetch),
        .t1           (t1_if.fetch),
        .btb          (btb_if.fetch),
        .branch_o     (branch_o),
        .pred_taken_o (pred_taken_o),
        .pred_pc_o    (pred_pc_o)
    );

    branch_update u_update (
        .clk          (clk),
        .rst          (rst),
        .ex_valid_i   (ex_branch_valid_i),
        .ex_taken_i   (ex_branch_taken_i),
        .ex_pc_i      (ex_pc_i),
        .ex_history_i (ex_history_i),
        .ex_target_i  (ex_target_i),
        .ghist_o      (ghist),
        .bm           (bm_if.update),
        .t0           (t0_if.update),
        .t1           (t1_if.update),
        .btb          (btb_if.update)
    );

    assign history_o = ghist;

endmodule

`default_nettype wire

//--- source/branch_update.sv
`default_nettype none

module branch_update (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 ex_valid_i,
    input  wire                 ex_taken_i,
    input  wire bpu_pkg::addr_t ex_pc_i,
    input  wire bpu_pkg::hist_t ex_history_i,
    input  wire bpu_pkg::addr_t ex_target_i,
    output bpu_pkg::hist_t      ghist_o,
    table_if.update             bm,
    table_if.update             t0,
    table_if.update             t1,
    table_if.update             btb
);

    bpu_pkg::hist_t            ghist_q;
    logic [bpu_pkg::tag_w-1:0] t0_tag_u;
    logic [bpu_pkg::tag_w-1:0] t1_tag_u;
    logic                      t0_hit;
    logic                      t1_hit;
    bpu_pkg::provider_e        provider;
    logic                      pred_dir;
    logic                      mispredict;
    bpu_pkg::counter_t         strong_ctr;
    bpu_pkg::counter_t         weak_ctr;
    logic                      t0_we;
    logic                      t1_we;
    bpu_pkg::tagged_entry_t    t0_wr;
    bpu_pkg::tagged_entry_t    t1_wr;
    bpu_pkg::btb_entry_t       btb_wr;

    // resolved outcome shifts in at the low end
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
        end else if (ex_valid_i) begin
            ghist_q <= {ghist_q[bpu_pkg::hist_w-2:0], ex_taken_i};
        end
    end

    assign ghist_o = ghist_q;

    assign bm.upd_idx  = bpu_pkg::bm_index(ex_pc_i);
    assign t0.upd_idx  = bpu_pkg::t0_index(ex_pc_i, ex_history_i);
    assign t1.upd_idx  = bpu_pkg::t1_index(ex_pc_i, ex_history_i);
    assign btb.upd_idx = bpu_pkg::btb_index(ex_pc_i);

    // redo the fetch-time lookup with the history the branch was predicted under
    assign t0_tag_u = bpu_pkg::t0_tag(ex_pc_i, ex_history_i);
    assign t1_tag_u = bpu_pkg::t1_tag(ex_pc_i, ex_history_i);
    assign t0_hit   = bpu_pkg::tag_hit(t0.upd_entry, t0_tag_u);
    assign t1_hit   = bpu_pkg::tag_hit(t1.upd_entry, t1_tag_u);

    always_comb begin
        if (t1_hit) begin
            provider = bpu_pkg::prov_t1;
            pred_dir = t1.upd_entry.ctr[1];
        end else if (t0_hit) begin
            provider = bpu_pkg::prov_t0;
            pred_dir = t0.upd_entry.ctr[1];
        end else begin
            provider = bpu_pkg::prov_bimodal;
            pred_dir = bm.upd_entry[1];
        end
    end

    assign mispredict = (pred_dir != ex_taken_i);
    assign strong_ctr = ex_taken_i ? bpu_pkg::ctr_strong_t : bpu_pkg::ctr_strong_nt;
    assign weak_ctr   = ex_taken_i ? bpu_pkg::ctr_weak_t : bpu_pkg::ctr_weak_nt;

    // bimodal trains on every report
    assign bm.wr_en    = ex_valid_i;
    assign bm.wr_idx   = bpu_pkg::bm_index(ex_pc_i);
    assign bm.wr_entry = bpu_pkg::ctr_step(bm.upd_entry, ex_taken_i);

    always_comb begin
        t0_we = 1'b0;
        t1_we = 1'b0;
        t0_wr = t0.upd_entry;
        t1_wr = t1.upd_entry;
        case (provider)
            bpu_pkg::prov_t1: begin
                t1_we     = 1'b1;
                t1_wr.ctr = mispredict ? strong_ctr
                                       : bpu_pkg::ctr_step(t1.upd_entry.ctr, ex_taken_i);
            end
            bpu_pkg::prov_t0: begin
                t0_we     = 1'b1;
                t0_wr.ctr = mispredict ? strong_ctr
                                       : bpu_pkg::ctr_step(t0.upd_entry.ctr, ex_taken_i);
            end
            default: begin
                // bimodal got it wrong, try T1 first then T0
                if (mispredict && (t1.upd_entry.tag != t1_tag_u)) begin
                    t1_we = 1'b1;
                    t1_wr = '{valid: 1'b1, tag: t1_tag_u, ctr: weak_ctr};
                end else if (mispredict && (t0.upd_entry.tag != t0_tag_u)) begin
                    t0_we = 1'b1;
                    t0_wr = '{valid: 1'b1, tag: t0_tag_u, ctr: weak_ctr};
                end
            end
        endcase
    end

    assign t0.wr_en    = ex_valid_i & t0_we;
    assign t0.wr_idx   = bpu_pkg::t0_index(ex_pc_i, ex_history_i);
    assign t0.wr_entry = t0_wr;
    assign t1.wr_en    = ex_valid_i & t1_we;
    assign t1.wr_idx   = bpu_pkg::t1_index(ex_pc_i, ex_history_i);
    assign t1.wr_entry = t1_wr;

    // skip the BTB write when the entry already holds this target
    assign btb_wr       = '{valid: 1'b1, tag: bpu_pkg::btb_tag(ex_pc_i), target: ex_target_i};
    assign btb.wr_en    = ex_valid_i & ex_taken_i & (btb.upd_entry != btb_wr);
    assign btb.wr_idx   = bpu_pkg::btb_index(ex_pc_i);
    assign btb.wr_entry = btb_wr;

endmodule

`default_nettype wire

//--- source/fetch_predictor.sv
`default_nettype none

module fetch_predictor (
    input  wire bpu_pkg::addr_t if_pc_i,
    input  wire bpu_pkg::addr_t if_inst_i,
    input  wire bpu_pkg::hist_t ghist_i,
    table_if.fetch              bm,
    table_if.fetch              t0,
    table_if.fetch              t1,
    table_if.fetch              btb,
    output logic                branch_o,
    output logic                pred_taken_o,
    output bpu_pkg::addr_t      pred_pc_o
);

    logic [6:0]         opcode;
    logic               is_branch;
    logic               is_jal;
    logic               is_jalr;
    logic               t0_hit;
    logic               t1_hit;
    logic               btb_hit;
    logic               cond_dir;
    bpu_pkg::provider_e provider;
    bpu_pkg::addr_t     imm_j;
    bpu_pkg::addr_t     imm_b;

    assign opcode    = if_inst_i[6:0];
    assign is_branch = (opcode == bpu_pkg::op_branch);
    assign is_jal    = (opcode == bpu_pkg::op_jal);
    assign is_jalr   = (opcode == bpu_pkg::op_jalr);

    // sign-extended J and B offsets
    assign imm_j = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                    if_inst_i[30:21], 1'b0};
    assign imm_b = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                    if_inst_i[11:8], 1'b0};

    assign bm.fetch_idx  = bpu_pkg::bm_index(if_pc_i);
    assign t0.fetch_idx  = bpu_pkg::t0_index(if_pc_i, ghist_i);
    assign t1.fetch_idx  = bpu_pkg::t1_index(if_pc_i, ghist_i);
    assign btb.fetch_idx = bpu_pkg::btb_index(if_pc_i);

    assign t0_hit  = bpu_pkg::tag_hit(t0.fetch_entry, bpu_pkg::t0_tag(if_pc_i, ghist_i));
    assign t1_hit  = bpu_pkg::tag_hit(t1.fetch_entry, bpu_pkg::t1_tag(if_pc_i, ghist_i));
    assign btb_hit = btb.fetch_entry.valid &&
                     (btb.fetch_entry.tag == bpu_pkg::btb_tag(if_pc_i));

    // longest history wins
    always_comb begin
        if (t1_hit) begin
            provider = bpu_pkg::prov_t1;
        end else if (t0_hit) begin
            provider = bpu_pkg::prov_t0;
        end else begin
            provider = bpu_pkg::prov_bimodal;
        end
    end

    always_comb begin
        case (provider)
            bpu_pkg::prov_t1: cond_dir = t1.fetch_entry.ctr[1];
            bpu_pkg::prov_t0: cond_dir = t0.fetch_entry.ctr[1];
            default:          cond_dir = bm.fetch_entry[1];
        endcase
    end

    // jalr always falls through, no return stack here
    assign branch_o     = is_branch | is_jal | is_jalr;
    assign pred_taken_o = is_jal | (is_branch & cond_dir);

    always_comb begin
        if (!pred_taken_o) begin
            pred_pc_o = if_pc_i + 32'd4;
        end else if (btb_hit) begin
            pred_pc_o = btb.fetch_entry.target;
        end else if (is_jal) begin
            pred_pc_o = if_pc_i + imm_j;
        end else begin
            pred_pc_o = if_pc_i + imm_b;
        end
    end

endmodule

`default_nettype wire

//--- source/pred_table.sv
`default_nettype none

module pred_table #(
    parameter type    entry_t    = logic [1:0],
    parameter int     idx_w      = 1,
    parameter entry_t init_entry = '0
) (
    input wire     clk,
    input wire     rst,
    table_if.store tbl
);

    entry_t mem [2**idx_w];

    // whole array returns to its idle value on reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**idx_w; i++) begin
                mem[i] <= init_entry;
            end
        end else if (tbl.wr_en) begin
            mem[tbl.wr_idx] <= tbl.wr_entry;
        end
    end

    // both reads are combinational and see pre-edge contents
    assign tbl.fetch_entry = mem[tbl.fetch_idx];
    assign tbl.upd_entry   = mem[tbl.upd_idx];

endmodule

`default_nettype wire

//--- source/table_if.sv
`default_nettype none

// one predictor table seen from fetch, update and storage
interface table_if #(
    parameter type entry_t = logic [1:0],
    parameter int  idx_w   = 1
) ();

    // fetch-side lookup
    logic [idx_w-1:0] fetch_idx;
    entry_t           fetch_entry;

    // execute-side lookup, same state as fetch sees
    logic [idx_w-1:0] upd_idx;
    entry_t           upd_entry;

    logic             wr_en;
    logic [idx_w-1:0] wr_idx;
    entry_t           wr_entry;

    modport store (
        input  fetch_idx, upd_idx, wr_en, wr_idx, wr_entry,
        output fetch_entry, upd_entry
    );

    modport fetch (
        output fetch_idx,
        input  fetch_entry
    );

    modport update (
        output upd_idx, wr_en, wr_idx, wr_entry,
        input  upd_entry
    );

endinterface

`default_nettype wire

//--- source/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    localparam int xlen      = 32;
    localparam int hist_w    = 16;
    localparam int bm_idx_w  = 9;
    localparam int tg_idx_w  = 8;
    localparam int btb_idx_w = 8;
    localparam int tag_w     = 10;
    localparam int partial_w = 6;
    localparam int btb_tag_w = 22;

    typedef logic [xlen-1:0]   addr_t;
    typedef logic [hist_w-1:0] hist_t;
    typedef logic [1:0]        counter_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        counter_t         ctr;
    } tagged_entry_t;

    typedef struct packed {
        logic                 valid;
        logic [btb_tag_w-1:0] tag;
        addr_t                target;
    } btb_entry_t;

    typedef enum logic [1:0] {
        prov_bimodal,
        prov_t0,
        prov_t1
    } provider_e;

    // msb of the counter is the predicted direction
    localparam counter_t ctr_strong_nt = 2'b00;
    localparam counter_t ctr_weak_nt   = 2'b01;
    localparam counter_t ctr_weak_t    = 2'b10;
    localparam counter_t ctr_strong_t  = 2'b11;

    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    localparam tagged_entry_t tagged_init = '{valid: 1'b0, tag: '0, ctr: ctr_weak_nt};
    localparam btb_entry_t    btb_init    = '{valid: 1'b0, tag: '0, target: '0};

    // T0 folds the low history half, T1 the high half
    function automatic logic [tg_idx_w-1:0] t0_index(addr_t pc, hist_t h);
        return pc[7:0] ^ h[7:0];
    endfunction

    function automatic logic [tg_idx_w-1:0] t1_index(addr_t pc, hist_t h);
        return pc[7:0] ^ h[15:8];
    endfunction

    function automatic logic [tag_w-1:0] t0_tag(addr_t pc, hist_t h);
        return pc[17:8] ^ h[15:6];
    endfunction

    function automatic logic [tag_w-1:0] t1_tag(addr_t pc, hist_t h);
        return pc[17:8] ^ {{(tag_w-8){1'b0}}, h[7:0]};
    endfunction

    function automatic logic [bm_idx_w-1:0] bm_index(addr_t pc);
        return pc[9:1];
    endfunction

    function automatic logic [btb_idx_w-1:0] btb_index(addr_t pc);
        return pc[9:2];
    endfunction

    function automatic logic [btb_tag_w-1:0] btb_tag(addr_t pc);
        return pc[xlen-1 -: btb_tag_w];
    endfunction

    // only the upper partial_w tag bits take part in the match
    function automatic logic tag_hit(tagged_entry_t e, logic [tag_w-1:0] tag);
        return e.valid && (e.tag[tag_w-1 -: partial_w] == tag[tag_w-1 -: partial_w]);
    endfunction

    function automatic counter_t ctr_step(counter_t c, logic taken);
        if (taken) begin
            return (c == ctr_strong_t) ? c : c + 2'd1;
        end
        return (c == ctr_strong_nt) ? c : c - 2'd1;
    endfunction

endpackage

`default_nettype wire
